//--- Makefile
# Verilator build and run of the Tomasulo core testbench

SIM := obj_dir/Vtomasulo_tb

all: run

$(SIM): compile.f logic/*.sv logic/*.svh bench/*.sv
	verilator --binary --timing --assert -Wno-fatal -f compile.f \
		--top-module tomasulo_tb -o Vtomasulo_tb

run: $(SIM)
	./$(SIM) > sim.log 2>&1; status=$$?; cat sim.log; exit $$status
	@if grep -q "Errors found" sim.log; then echo "Simulation failed"; exit 1; fi
	@echo "Simulation passed"

lint:
	verilator --lint-only --timing -Wall -f compile.f --top-module tomasulo_tb

clean:
	rm -rf obj_dir sim.log

.PHONY: all run lint clean

//--- bench/tb_clock.sv
`timescale 1ns/100ps

module tb_clock (
    output logic clk
);

    // Free-running 10 ns clock, low at time zero
    initial begin
        clk = 1'b0;
    end

    always #5 clk = ~clk;

endmodule

//--- bench/tomasulo_assertions.sv
`timescale 1ns/100ps

`include "tomasulo_defs.svh"

module tomasulo_assertions
    import tomasulo_pkg::*;
(
    input logic                 clk,
    input logic                 rst,
    input logic                 disp_valid,
    input logic [`TAG_BITS-1:0] alloc_tag,
    input logic                 table_full,
    input logic                 busy,
    input logic                 issue_valid,
    input logic [`TAG_BITS-1:0] issue_tag,
    input slot_state_t          state [`RS_DEPTH]
);

    // Failed checks so far
    int failures = 0;

    // Dispatch only writes a free slot, and a full station has none
    assert property (@(posedge clk) disable iff (rst)
        disp_valid |-> (state[alloc_tag] == SLOT_FREE))
        else begin
            failures++;
            $error("dispatch wrote into a slot that is not free");
        end

    // Issued slot stays reserved while its issue register is live
    assert property (@(posedge clk) disable iff (rst)
        issue_valid |-> (state[issue_tag] != SLOT_FREE))
        else begin
            failures++;
            $error("issue_valid high for a free slot");
        end

    // First cycle out of reset is quiet
    assert property (@(posedge clk) $fell(rst) |-> (!table_full && !busy && !issue_valid))
        else begin
            failures++;
            $error("stall, busy or issue_valid high right after reset");
        end

endmodule

//--- bench/tomasulo_tb.sv
`timescale 1ns/100ps

`include "tomasulo_defs.svh"

module tomasulo_tb
    import tomasulo_pkg::*;
();

    localparam int WAIT_LIMIT = 200;

    logic                  clk;
    logic                  rst;
    logic                  inst_valid;
    fu_op_t                inst_op;
    logic [`AREG_BITS-1:0] inst_rd;
    logic [`AREG_BITS-1:0] inst_rs1;
    logic [`AREG_BITS-1:0] inst_rs2;
    logic [`XLEN-1:0]      inst_imm;
    logic                  stall;
    logic                  busy;
    logic                  cdb_valid;
    logic [`TAG_BITS-1:0]  cdb_tag;
    logic [`XLEN-1:0]      cdb_value;
    logic [`AREG_BITS-1:0] rd_addr;
    logic [`XLEN-1:0]      rd_data;

    integer                seed;
    int                    errors;
    int                    accepted;
    int                    broadcasts = 0;
    logic                  stall_seen;
    // Sequential model of the register file
    logic [`XLEN-1:0]      model_regs [`NUM_AREGS];
    // Station slots held by accepted instructions and the result each one owes
    logic                  tag_busy   [`RS_DEPTH];
    logic [`XLEN-1:0]      tag_result [`RS_DEPTH];

    tb_clock u_clock (
        .clk (clk)
    );

    tomasulo_core DUT (
        .clk        (clk),
        .rst        (rst),
        .inst_valid (inst_valid),
        .inst_op    (inst_op),
        .inst_rd    (inst_rd),
        .inst_rs1   (inst_rs1),
        .inst_rs2   (inst_rs2),
        .inst_imm   (inst_imm),
        .stall      (stall),
        .busy       (busy),
        .cdb_valid  (cdb_valid),
        .cdb_tag    (cdb_tag),
        .cdb_value  (cdb_value),
        .rd_addr    (rd_addr),
        .rd_data    (rd_data)
    );

    bind reservation_station tomasulo_assertions u_assertions (
        .clk         (clk),
        .rst         (rst),
        .disp_valid  (disp_valid),
        .alloc_tag   (alloc_tag),
        .table_full  (table_full),
        .busy        (busy),
        .issue_valid (issue_valid),
        .issue_tag   (issue_tag),
        .state       (state)
    );

    // Count each CDB pulse mid-cycle and match it against the result its tag owes
    always @(negedge clk) begin
        if (cdb_valid === 1'b1) begin
            broadcasts++;
            if (tag_busy[cdb_tag] !== 1'b1) begin
                $display("Error at %0t: CDB broadcast on tag %0d with no instruction in flight",
                         $time, cdb_tag);
                errors++;
            end else if (cdb_value !== tag_result[cdb_tag]) begin
                $display("Mismatch at %0t: cdb_value for tag %0d expected %h got %h",
                         $time, cdb_tag, tag_result[cdb_tag], cdb_value);
                errors++;
            end
            tag_busy[cdb_tag] = 1'b0;
        end
    end

    // Expected result per operation
    function automatic logic [`XLEN-1:0] reference_result(
        input fu_op_t           op,
        input logic [`XLEN-1:0] a,
        input logic [`XLEN-1:0] b,
        input logic [`XLEN-1:0] imm
    );
        case (op)
            OP_LI:   return imm;
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_AND:  return a & b;
            OP_OR:   return a | b;
            OP_XOR:  return a ^ b;
            OP_SLT:  return ($signed(a) < $signed(b)) ? `XLEN'd1 : `XLEN'd0;
            OP_MUL:  return a * b;
            default: return '0;
        endcase
    endfunction

    // Lowest slot neither held nor retiring on the bus this cycle
    function automatic logic [`TAG_BITS-1:0] lowest_free_tag();
        for (int t = 0; t < `RS_DEPTH; t++) begin
            if (!tag_busy[t] && !((cdb_valid === 1'b1) && (cdb_tag == t))) begin
                return `TAG_BITS'(t);
            end
        end
        return '0;
    endfunction

    function automatic logic [`XLEN-1:0] random_word();
        return $random(seed);
    endfunction

    function automatic logic [`AREG_BITS-1:0] random_reg();
        logic [`XLEN-1:0] r;
        r = $random(seed);
        return r[`AREG_BITS-1:0];
    endfunction

    function automatic fu_op_t random_op();
        logic [`XLEN-1:0] r;
        r = $random(seed);
        return fu_op_t'(r[2:0]);
    endfunction

    // Strobe one instruction, hold it while stalled, model it once taken
    task automatic send(
        input fu_op_t                op,
        input logic [`AREG_BITS-1:0] rd,
        input logic [`AREG_BITS-1:0] rs1,
        input logic [`AREG_BITS-1:0] rs2,
        input logic [`XLEN-1:0]      imm
    );
        int                   waited;
        logic [`TAG_BITS-1:0] tag;
        logic [`XLEN-1:0]     result;
        waited = 0;
        @(negedge clk);
        inst_valid = 1'b1;
        inst_op    = op;
        inst_rd    = rd;
        inst_rs1   = rs1;
        inst_rs2   = rs2;
        inst_imm   = imm;
        while (stall) begin
            stall_seen = 1'b1;
            if (waited == WAIT_LIMIT) begin
                $display("Timeout at %0t: station stayed full, instruction never sent", $time);
                errors++;
                inst_valid = 1'b0;
                return;
            end
            waited++;
            @(negedge clk);
        end
        tag             = lowest_free_tag();
        result          = reference_result(op, model_regs[rs1], model_regs[rs2], imm);
        model_regs[rd]  = result;
        tag_result[tag] = result;
        tag_busy[tag]   = 1'b1;
        accepted++;
        // Acceptance edge
        @(posedge clk);
    endtask

    // Idle the source until the station empties
    task automatic drain(input string phase);
        int waited;
        waited = 0;
        @(negedge clk);
        inst_valid = 1'b0;
        while (busy) begin
            if (waited == WAIT_LIMIT) begin
                $display("Timeout at %0t: busy never fell in the %s phase", $time, phase);
                errors++;
                break;
            end
            waited++;
            @(negedge clk);
        end
        // Each accepted instruction broadcasts exactly once
        if (broadcasts != accepted) begin
            $display("Mismatch at %0t: cdb_valid pulse count expected %0d got %0d",
                     $time, accepted, broadcasts);
            errors++;
        end
    endtask

    // Read back every architectural register
    task automatic check_regs();
        for (int i = 0; i < `NUM_AREGS; i++) begin
            @(negedge clk);
            rd_addr = `AREG_BITS'(i);
            #1;
            if (rd_data !== model_regs[i]) begin
                $display("Mismatch at %0t: rd_data for r%0d expected %h got %h",
                         $time, i, model_regs[i], rd_data);
                errors++;
            end
        end
    endtask

    initial begin
        logic [`AREG_BITS-1:0] prev;
        logic [`AREG_BITS-1:0] hot;
        logic [`XLEN-1:0]      bits;
        fu_op_t                op;

        seed       = 25252;
        errors     = 0;
        accepted   = 0;
        stall_seen = 1'b0;
        rst        = 1'b1;
        inst_valid = 1'b0;
        inst_op    = OP_LI;
        inst_rd    = '0;
        inst_rs1   = '0;
        inst_rs2   = '0;
        inst_imm   = '0;
        rd_addr    = '0;
        for (int i = 0; i < `NUM_AREGS; i++) begin
            model_regs[i] = '0;
        end
        for (int i = 0; i < `RS_DEPTH; i++) begin
            tag_busy[i] = 1'b0;
        end

        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // Quiet core with a zeroed register file
        @(negedge clk);
        if (stall !== 1'b0) begin
            $display("Mismatch at %0t: stall expected 0 got %b", $time, stall);
            errors++;
        end
        if (busy !== 1'b0) begin
            $display("Mismatch at %0t: busy expected 0 got %b", $time, busy);
            errors++;
        end
        check_regs();

        // Seed all registers, then unrelated random work
        for (int i = 0; i < `NUM_AREGS; i++) begin
            send(OP_LI, `AREG_BITS'(i), '0, '0, random_word());
        end
        repeat (24) send(random_op(), random_reg(), random_reg(), random_reg(), random_word());
        drain("random");
        check_regs();

        // Each instruction reads the previous destination
        prev = random_reg();
        repeat (20) begin
            op = random_op();
            if (op == OP_LI) begin
                op = OP_ADD;
            end
            hot = random_reg();
            send(op, hot, prev, random_reg(), random_word());
            prev = hot;
        end
        drain("dependent");
        check_regs();

        // Long mul and add chains strobed every cycle to fill the station
        stall_seen = 1'b0;
        prev       = random_reg();
        repeat (40) begin
            bits = random_word();
            op   = bits[0] ? OP_MUL : OP_ADD;
            hot  = random_reg();
            send(op, hot, prev, random_reg(), '0);
            prev = hot;
        end
        if (!stall_seen) begin
            $display("Error at %0t: stall never rose during the chain phase", $time);
            errors++;
        end
        drain("chain");
        check_regs();

        // Same register written over and over and read in between
        hot = random_reg();
        repeat (16) begin
            bits = random_word();
            prev = bits[0] ? hot : random_reg();
            send(random_op(), prev, hot, random_reg(), random_word());
        end
        drain("overwrite");
        check_regs();

        // Station checker failures count as errors too
        errors += DUT.u_rs.u_assertions.failures;

        $display("Summary: %0d errors, %0d instructions accepted, %0d CDB broadcasts",
                 errors, accepted, broadcasts);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

//--- compile.f
+incdir+logic
logic/tomasulo_pkg.sv
logic/dispatch_unit.sv
logic/reservation_station.sv
logic/exec_unit.sv
logic/tomasulo_core.sv
bench/tb_clock.sv
bench/tomasulo_assertions.sv
bench/tomasulo_tb.sv

//--- logic/dispatch_unit.sv
`timescale 1ns/100ps

`include "tomasulo_defs.svh"

module dispatch_unit
    import tomasulo_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    // Incoming instruction strobe
    input  logic                  inst_valid,
    input  fu_op_t                inst_op,
    input  logic [`AREG_BITS-1:0] inst_rd,
    input  logic [`AREG_BITS-1:0] inst_rs1,
    input  logic [`AREG_BITS-1:0] inst_rs2,
    input  logic [`XLEN-1:0]      inst_imm,
    // Station status
    input  logic                  table_full,
    input  logic [`TAG_BITS-1:0]  alloc_tag,
    // Common data bus
    input  logic                  cdb_valid,
    input  logic [`TAG_BITS-1:0]  cdb_tag,
    input  logic [`XLEN-1:0]      cdb_value,
    // Architectural readback
    input  logic [`AREG_BITS-1:0] rd_addr,
    output logic [`XLEN-1:0]      rd_data,
    // New station entry
    output logic                  disp_valid,
    output fu_op_t                disp_op,
    output logic                  src1_ready,
    output logic [`TAG_BITS-1:0]  src1_tag,
    output logic [`XLEN-1:0]      src1_value,
    output logic                  src2_ready,
    output logic [`TAG_BITS-1:0]  src2_tag,
    output logic [`XLEN-1:0]      src2_value
);

    // Architectural values
    logic [`XLEN-1:0]     regs    [`NUM_AREGS];
    // Register status table, one pending writer per register
    logic                 pending [`NUM_AREGS];
    logic [`TAG_BITS-1:0] ptag    [`NUM_AREGS];

    // Operand lookup: file value, same-cycle CDB forward, or producer tag
    function automatic void resolve_src(
        input  logic [`AREG_BITS-1:0] idx,
        output logic                  rdy,
        output logic [`TAG_BITS-1:0]  tag,
        output logic [`XLEN-1:0]      val
    );
        rdy = 1'b1;
        tag = ptag[idx];
        val = regs[idx];
        if (pending[idx]) begin
            // Result on the bus right now counts as ready
            if (cdb_valid && (ptag[idx] == cdb_tag)) begin
                val = cdb_value;
            end else begin
                rdy = 1'b0;
            end
        end
    endfunction

    // Accept only while the station has room
    assign disp_valid = inst_valid && !table_full;
    assign disp_op    = inst_op;

    always_comb begin
        resolve_src(inst_rs1, src1_ready, src1_tag, src1_value);
        resolve_src(inst_rs2, src2_ready, src2_tag, src2_value);
        // Load immediate carries its value in both operands
        if (inst_op == OP_LI) begin
            src1_ready = 1'b1;
            src1_value = inst_imm;
            src2_ready = 1'b1;
            src2_value = inst_imm;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `NUM_AREGS; i++) begin
                regs[i]    <= '0;
                pending[i] <= 1'b0;
                ptag[i]    <= '0;
            end
        end else begin
            // Retire only if this tag is still the newest writer
            if (cdb_valid) begin
                for (int i = 0; i < `NUM_AREGS; i++) begin
                    if (pending[i] && (ptag[i] == cdb_tag)) begin
                        regs[i]    <= cdb_value;
                        pending[i] <= 1'b0;
                    end
                end
            end
            // Rename the destination, overriding a same-cycle retire
            if (disp_valid) begin
                pending[inst_rd] <= 1'b1;
                ptag[inst_rd]    <= alloc_tag;
            end
        end
    end

    assign rd_data = regs[rd_addr];

endmodule

//--- logic/exec_unit.sv
`timescale 1ns/100ps

`include "tomasulo_defs.svh"

module exec_unit
    import tomasulo_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    // From the station issue register
    input  logic                 issue_valid,
    input  fu_op_t               issue_op,
    input  logic [`TAG_BITS-1:0] issue_tag,
    input  logic [`XLEN-1:0]     issue_a,
    input  logic [`XLEN-1:0]     issue_b,
    // Result broadcast
    output logic                 cdb_valid,
    output logic [`TAG_BITS-1:0] cdb_tag,
    output logic [`XLEN-1:0]     cdb_value
);

    // Stage 1 holding registers
    logic                 s1_valid;
    fu_op_t               s1_op;
    logic [`TAG_BITS-1:0] s1_tag;
    logic [`XLEN-1:0]     s1_a;
    logic [`XLEN-1:0]     s1_b;

    logic [`XLEN-1:0]     result;

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= issue_valid;
        end
        s1_op  <= issue_op;
        s1_tag <= issue_tag;
        s1_a   <= issue_a;
        s1_b   <= issue_b;
    end

    // Stage 2 ALU, multiply keeps only the low word
    always_comb begin
        case (s1_op)
            OP_LI:   result = s1_a;
            OP_ADD:  result = s1_a + s1_b;
            OP_SUB:  result = s1_a - s1_b;
            OP_AND:  result = s1_a & s1_b;
            OP_OR:   result = s1_a | s1_b;
            OP_XOR:  result = s1_a ^ s1_b;
            OP_SLT:  result = ($signed(s1_a) < $signed(s1_b)) ? `XLEN'd1 : `XLEN'd0;
            OP_MUL:  result = s1_a * s1_b;
            default: result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            cdb_valid <= 1'b0;
        end else begin
            cdb_valid <= s1_valid;
        end
        cdb_tag   <= s1_tag;
        cdb_value <= result;
    end

endmodule

//--- logic/reservation_station.sv
`timescale 1ns/100ps

`include "tomasulo_defs.svh"

module reservation_station
    import tomasulo_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    // Allocation from dispatch
    input  logic                 disp_valid,
    input  fu_op_t               disp_op,
    input  logic                 src1_ready,
    input  logic [`TAG_BITS-1:0] src1_tag,
    input  logic [`XLEN-1:0]     src1_value,
    input  logic                 src2_ready,
    input  logic [`TAG_BITS-1:0] src2_tag,
    input  logic [`XLEN-1:0]     src2_value,
    // Common data bus
    input  logic                 cdb_valid,
    input  logic [`TAG_BITS-1:0] cdb_tag,
    input  logic [`XLEN-1:0]     cdb_value,
    // Status
    output logic [`TAG_BITS-1:0] alloc_tag,
    output logic                 table_full,
    output logic                 busy,
    // Issue to the execution unit
    output logic                 issue_valid,
    output fu_op_t               issue_op,
    output logic [`TAG_BITS-1:0] issue_tag,
    output logic [`XLEN-1:0]     issue_a,
    output logic [`XLEN-1:0]     issue_b
);

    // Per-slot contents
    slot_state_t          state   [`RS_DEPTH];
    fu_op_t               op      [`RS_DEPTH];
    logic                 a_ready [`RS_DEPTH];
    logic [`TAG_BITS-1:0] a_tag   [`RS_DEPTH];
    logic [`XLEN-1:0]     a_val   [`RS_DEPTH];
    logic                 b_ready [`RS_DEPTH];
    logic [`TAG_BITS-1:0] b_tag   [`RS_DEPTH];
    logic [`XLEN-1:0]     b_val   [`RS_DEPTH];

    logic [`TAG_BITS:0]   used_count;
    logic                 sel_found;
    logic [`TAG_BITS-1:0] sel_idx;

    always_comb begin
        used_count = '0;
        alloc_tag  = '0;
        sel_found  = 1'b0;
        sel_idx    = '0;
        // Scan downward so the lowest index wins
        for (int i = `RS_DEPTH - 1; i >= 0; i--) begin
            if (state[i] == SLOT_FREE) begin
                alloc_tag = `TAG_BITS'(i);
            end else begin
                used_count = used_count + 1'b1;
            end
            if ((state[i] == SLOT_WAIT) && a_ready[i] && b_ready[i]) begin
                sel_found = 1'b1;
                sel_idx   = `TAG_BITS'(i);
            end
        end
    end

    assign table_full = (used_count == `RS_DEPTH);
    assign busy       = (used_count != '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `RS_DEPTH; i++) begin
                state[i] <= SLOT_FREE;
            end
            issue_valid <= 1'b0;
        end else begin
            // Wakeup of waiting operands
            if (cdb_valid) begin
                for (int i = 0; i < `RS_DEPTH; i++) begin
                    if (state[i] == SLOT_WAIT) begin
                        if (!a_ready[i] && (a_tag[i] == cdb_tag)) begin
                            a_ready[i] <= 1'b1;
                            a_val[i]   <= cdb_value;
                        end
                        if (!b_ready[i] && (b_tag[i] == cdb_tag)) begin
                            b_ready[i] <= 1'b1;
                            b_val[i]   <= cdb_value;
                        end
                    end
                end
                // Broadcast ends the producer's life, tag is reusable
                state[cdb_tag] <= SLOT_FREE;
            end

            // Allocation, dispatch already checked for room
            if (disp_valid) begin
                state[alloc_tag]   <= SLOT_WAIT;
                op[alloc_tag]      <= disp_op;
                a_ready[alloc_tag] <= src1_ready;
                a_tag[alloc_tag]   <= src1_tag;
                a_val[alloc_tag]   <= src1_value;
                b_ready[alloc_tag] <= src2_ready;
                b_tag[alloc_tag]   <= src2_tag;
                b_val[alloc_tag]   <= src2_value;
            end

            // One issue per cycle
            issue_valid <= sel_found;
            if (sel_found) begin
                state[sel_idx] <= SLOT_EXEC;
                issue_op       <= op[sel_idx];
                issue_tag      <= sel_idx;
                issue_a        <= a_val[sel_idx];
                issue_b        <= b_val[sel_idx];
            end
        end
    end

endmodule

//--- logic/tomasulo_core.sv
`timescale 1ns/100ps

`include "tomasulo_defs.svh"

module tomasulo_core
    import tomasulo_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  inst_valid,
    input  fu_op_t                inst_op,
    input  logic [`AREG_BITS-1:0] inst_rd,
    input  logic [`AREG_BITS-1:0] inst_rs1,
    input  logic [`AREG_BITS-1:0] inst_rs2,
    input  logic [`XLEN-1:0]      inst_imm,
    output logic                  stall,
    output logic                  busy,
    output logic                  cdb_valid,
    output logic [`TAG_BITS-1:0]  cdb_tag,
    output logic [`XLEN-1:0]      cdb_value,
    input  logic [`AREG_BITS-1:0] rd_addr,
    output logic [`XLEN-1:0]      rd_data
);

    // Dispatch to station
    logic                 disp_valid;
    fu_op_t               disp_op;
    logic                 src1_ready;
    logic [`TAG_BITS-1:0] src1_tag;
    logic [`XLEN-1:0]     src1_value;
    logic                 src2_ready;
    logic [`TAG_BITS-1:0] src2_tag;
    logic [`XLEN-1:0]     src2_value;
    logic [`TAG_BITS-1:0] alloc_tag;

    // Station to execution unit
    logic                 issue_valid;
    fu_op_t               issue_op;
    logic [`TAG_BITS-1:0] issue_tag;
    logic [`XLEN-1:0]     issue_a;
    logic [`XLEN-1:0]     issue_b;

    // Station full doubles as the source stall
    dispatch_unit u_dispatch (
        .clk        (clk),
        .rst        (rst),
        .inst_valid (inst_valid),
        .inst_op    (inst_op),
        .inst_rd    (inst_rd),
        .inst_rs1   (inst_rs1),
        .inst_rs2   (inst_rs2),
        .inst_imm   (inst_imm),
        .table_full (stall),
        .alloc_tag  (alloc_tag),
        .cdb_valid  (cdb_valid),
        .cdb_tag    (cdb_tag),
        .cdb_value  (cdb_value),
        .rd_addr    (rd_addr),
        .rd_data    (rd_data),
        .disp_valid (disp_valid),
        .disp_op    (disp_op),
        .src1_ready (src1_ready),
        .src1_tag   (src1_tag),
        .src1_value (src1_value),
        .src2_ready (src2_ready),
        .src2_tag   (src2_tag),
        .src2_value (src2_value)
    );

    reservation_station u_rs (
        .clk         (clk),
        .rst         (rst),
        .disp_valid  (disp_valid),
        .disp_op     (disp_op),
        .src1_ready  (src1_ready),
        .src1_tag    (src1_tag),
        .src1_value  (src1_value),
        .src2_ready  (src2_ready),
        .src2_tag    (src2_tag),
        .src2_value  (src2_value),
        .cdb_valid   (cdb_valid),
        .cdb_tag     (cdb_tag),
        .cdb_value   (cdb_value),
        .alloc_tag   (alloc_tag),
        .table_full  (stall),
        .busy        (busy),
        .issue_valid (issue_valid),
        .issue_op    (issue_op),
        .issue_tag   (issue_tag),
        .issue_a     (issue_a),
        .issue_b     (issue_b)
    );

    exec_unit u_exec (
        .clk         (clk),
        .rst         (rst),
        .issue_valid (issue_valid),
        .issue_op    (issue_op),
        .issue_tag   (issue_tag),
        .issue_a     (issue_a),
        .issue_b     (issue_b),
        .cdb_valid   (cdb_valid),
        .cdb_tag     (cdb_tag),
        .cdb_value   (cdb_value)
    );

endmodule

//--- logic/tomasulo_defs.svh
`ifndef TOMASULO_DEFS_SVH
`define TOMASULO_DEFS_SVH

// Datapath width
`define XLEN 32

// Architectural register file
`define NUM_AREGS 8
`define AREG_BITS 3

// Reservation station size, one tag per slot
`define RS_DEPTH 8
`define TAG_BITS 3

`endif

//--- logic/tomasulo_pkg.sv
package tomasulo_pkg;

    // Operations understood by the execution unit
    typedef enum logic [2:0] {
        OP_LI  = 3'd0,
        OP_ADD = 3'd1,
        OP_SUB = 3'd2,
        OP_AND = 3'd3,
        OP_OR  = 3'd4,
        OP_XOR = 3'd5,
        OP_SLT = 3'd6,
        OP_MUL = 3'd7
    } fu_op_t;

    // Lifetime of one station slot
    // Exec keeps the tag reserved until the result is broadcast
    typedef enum logic [1:0] {
        SLOT_FREE = 2'd0,
        SLOT_WAIT = 2'd1,
        SLOT_EXEC = 2'd2
    } slot_state_t;

endpackage
